//--- mem_access_macros.svh
// address base, RAM depth and data width for the memory access unit, include where needed
`ifndef MEM_ACCESS_MACROS_SVH
`define MEM_ACCESS_MACROS_SVH

// byte address of RAM word 0
`define MEM_BASE 64'h0000_0000_8000_0000

// data path width in bits
`define DATA_W 64

// log2 of the RAM depth in 64-bit words
`define RAM_AW 9

`endif

//--- mem_access_pkg.sv
// shared opcode and sequencer state enums for the memory access unit
`default_nettype none

package mem_access_pkg;

  // RISC-V load funct3 codes
  // stores only look at the low two bits for the size
  typedef enum logic [2:0] {
    lb  = 3'd0,
    lh  = 3'd1,
    lw  = 3'd2,
    ld  = 3'd3,
    lbu = 3'd4,
    lhu = 3'd5,
    lwu = 3'd6
  } funct3_e;

  // sequencer states
  typedef enum logic [1:0] {
    idle   = 2'd0,
    first  = 2'd1,
    second = 2'd2,
    finish = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

//--- mem_access_ifs.sv
// interfaces between decoder, sequencer, RAM and load aligner, compiled before the modules
`default_nettype none

`include "mem_access_macros.svh"

// decoded request, decoder to sequencer
interface mem_req_if;
  logic                       valid;
  logic                       is_store;
  logic [`RAM_AW-1:0]         word_idx;
  logic [2:0]                 offset;
  mem_access_pkg::funct3_e    funct3;
  logic                       split;
  logic [`DATA_W/8-1:0]       wmask_lo;
  logic [`DATA_W/8-1:0]       wmask_hi;
  logic [`DATA_W-1:0]         wdata_lo;
  logic [`DATA_W-1:0]         wdata_hi;

  modport src (output valid, is_store, word_idx, offset, funct3, split,
               output wmask_lo, wmask_hi, wdata_lo, wdata_hi);
  modport dst (input valid, is_store, word_idx, offset, funct3, split,
               input wmask_lo, wmask_hi, wdata_lo, wdata_hi);
endinterface

// single word port, sequencer to RAM
interface ram_port_if;
  logic                       en;
  logic                       we;
  logic [`RAM_AW-1:0]         addr;
  logic [`DATA_W-1:0]         wdata;
  logic [`DATA_W/8-1:0]       wmask;
  logic [`DATA_W-1:0]         rdata;

  modport master (output en, we, addr, wdata, wmask, input rdata);
  modport slave (input en, we, addr, wdata, wmask, output rdata);
endinterface

// finished access with raw words, sequencer to aligner
interface load_if;
  logic                       valid;
  logic                       is_store;
  logic [2:0]                 offset;
  mem_access_pkg::funct3_e    funct3;
  logic [`DATA_W-1:0]         word_lo;
  logic [`DATA_W-1:0]         word_hi;

  modport src (output valid, is_store, offset, funct3, word_lo, word_hi);
  modport dst (input valid, is_store, offset, funct3, word_lo, word_hi);
endinterface

`default_nettype wire

//--- mem_req_decoder.sv
// request front end, captures a byte-addressed access and decodes it for the sequencer
`default_nettype none

`include "mem_access_macros.svh"

module mem_req_decoder (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 req,
  input  wire logic                 is_store,
  input  wire logic [`DATA_W-1:0]   addr,
  input  wire logic [2:0]           funct3,
  input  wire logic [`DATA_W-1:0]   wdata,
  input  wire logic                 busy,
  mem_req_if.src                    out
);

  logic [`DATA_W-1:0]     rel_addr;
  logic [2:0]             offset;
  logic [3:0]             nbytes;
  logic [3:0]             end_byte;
  logic [7:0]             size_mask;
  logic [15:0]            wide_mask;
  logic [2*`DATA_W-1:0]   wide_data;
  logic                   take;

  assign rel_addr = addr - `MEM_BASE;
  assign offset   = rel_addr[2:0];
  assign nbytes   = 4'd1 << funct3[1:0];

  // one past the last byte touched, beyond 8 means the next word too
  assign end_byte = {1'b0, offset} + nbytes;

  always_comb begin
    case (funct3[1:0])
      2'b00:   size_mask = 8'h01;
      2'b01:   size_mask = 8'h03;
      2'b10:   size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // place mask and data across a two word window
  assign wide_mask = {8'h00, size_mask} << offset;
  assign wide_data = {{`DATA_W{1'b0}}, wdata} << {offset, 3'b000};

  // requests during an access are dropped
  assign take = req & ~busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= take;
    end
  end

  // payload is held until the next accepted request
  always_ff @(posedge clk) begin
    if (take) begin
      out.is_store <= is_store;
      out.word_idx <= rel_addr[`RAM_AW+2:3];
      out.offset   <= offset;
      out.funct3   <= mem_access_pkg::funct3_e'(funct3);
      out.split    <= (end_byte > 4'd8);
      out.wmask_lo <= wide_mask[7:0];
      out.wmask_hi <= wide_mask[15:8];
      out.wdata_lo <= wide_data[`DATA_W-1:0];
      out.wdata_hi <= wide_data[2*`DATA_W-1:`DATA_W];
    end
  end

endmodule

`default_nettype wire

//--- mem_access_seq.sv
// access sequencer, turns one decoded request into one or two word RAM cycles
`default_nettype none

`include "mem_access_macros.svh"

module mem_access_seq (
  input  wire logic   clk,
  input  wire logic   arst_n,
  mem_req_if.dst      in,
  ram_port_if.master  ram,
  load_if.src         ld,
  output logic        busy
);

  mem_access_pkg::seq_state_e state_q;
  mem_access_pkg::seq_state_e state_d;
  logic [`DATA_W-1:0]         word_lo_q;
  logic                       on_first;

  // the decoder payload stays stable while busy is high,
  // so the request fields are read straight from the interface
  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_access_pkg::idle: begin
        if (in.valid) begin
          state_d = mem_access_pkg::first;
        end
      end
      mem_access_pkg::first: begin
        if (in.split) begin
          state_d = mem_access_pkg::second;
        end else begin
          state_d = mem_access_pkg::finish;
        end
      end
      mem_access_pkg::second: begin
        state_d = mem_access_pkg::finish;
      end
      default: begin
        state_d = mem_access_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= mem_access_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // RAM port
  assign on_first  = (state_q == mem_access_pkg::first);
  assign ram.en    = on_first | (state_q == mem_access_pkg::second);
  assign ram.we    = ram.en & in.is_store;
  assign ram.addr  = on_first ? in.word_idx : in.word_idx + 1'b1;
  assign ram.wdata = on_first ? in.wdata_lo : in.wdata_hi;
  assign ram.wmask = on_first ? in.wmask_lo : in.wmask_hi;

  // first word of a split access returns while the second is issued
  always_ff @(posedge clk) begin
    if (state_q == mem_access_pkg::second) begin
      word_lo_q <= ram.rdata;
    end
  end

  // last word is taken directly off the RAM read port
  assign ld.valid    = (state_q == mem_access_pkg::finish);
  assign ld.is_store = in.is_store;
  assign ld.offset   = in.offset;
  assign ld.funct3   = in.funct3;
  assign ld.word_lo  = in.split ? word_lo_q : ram.rdata;
  assign ld.word_hi  = ram.rdata;

  // covers the decoder strobe cycle as well, drops when done rises
  assign busy = (state_q != mem_access_pkg::idle) | in.valid;

endmodule

`default_nettype wire

//--- word_ram.sv
// 64-bit word RAM with byte write mask and registered read, used as the unit's backing store
`default_nettype none

`include "mem_access_macros.svh"

module word_ram #(
  parameter int depth = 1 << `RAM_AW
) (
  input  wire logic  clk,
  ram_port_if.slave  port
);

  logic [`DATA_W-1:0] mem [depth];

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // read returns the old word when the same cycle writes
  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        for (int b = 0; b < `DATA_W/8; b++) begin
          if (port.wmask[b]) begin
            mem[port.addr][8*b +: 8] <= port.wdata[8*b +: 8];
          end
        end
      end
      port.rdata <= mem[port.addr];
    end
  end

endmodule

`default_nettype wire

//--- load_aligner.sv
// load result stage, realigns the raw words and extends the value per funct3
`default_nettype none

`include "mem_access_macros.svh"

module load_aligner (
  input  wire logic           clk,
  input  wire logic           arst_n,
  load_if.dst                 ld,
  output logic                done,
  output logic [`DATA_W-1:0]  rdata
);

  logic [2*`DATA_W-1:0] joined;
  logic [`DATA_W-1:0]   raw;
  logic [`DATA_W-1:0]   ext;

  // requested bytes start at bit 0 after the shift
  assign joined = {ld.word_hi, ld.word_lo} >> {ld.offset, 3'b000};
  assign raw    = joined[`DATA_W-1:0];

  always_comb begin
    case (ld.funct3)
      mem_access_pkg::lb:  ext = {{56{raw[7]}}, raw[7:0]};
      mem_access_pkg::lh:  ext = {{48{raw[15]}}, raw[15:0]};
      mem_access_pkg::lw:  ext = {{32{raw[31]}}, raw[31:0]};
      mem_access_pkg::lbu: ext = {56'd0, raw[7:0]};
      mem_access_pkg::lhu: ext = {48'd0, raw[15:0]};
      mem_access_pkg::lwu: ext = {32'd0, raw[31:0]};
      default:             ext = raw;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done  <= 1'b0;
      rdata <= '0;
    end else begin
      done <= ld.valid;
      // stores leave the last load result in place
      if (ld.valid && !ld.is_store) begin
        rdata <= ext;
      end
    end
  end

endmodule

`default_nettype wire

//--- mem_access_top.sv
// top level of the load/store memory access unit, plain strobe ports toward the core
`default_nettype none

`include "mem_access_macros.svh"

module mem_access_top (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 req,
  input  wire logic                 is_store,
  input  wire logic [`DATA_W-1:0]   addr,
  input  wire logic [2:0]           funct3,
  input  wire logic [`DATA_W-1:0]   wdata,
  output logic                      done,
  output logic [`DATA_W-1:0]        rdata,
  output logic                      busy
);

  mem_req_if  req_bus ();
  ram_port_if ram_bus ();
  load_if     ld_bus ();

  // request capture and decode
  mem_req_decoder mem_req_decoder_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .is_store (is_store),
    .addr     (addr),
    .funct3   (funct3),
    .wdata    (wdata),
    .busy     (busy),
    .out      (req_bus)
  );

  mem_access_seq mem_access_seq_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (req_bus),
    .ram    (ram_bus),
    .ld     (ld_bus),
    .busy   (busy)
  );

  word_ram #(
    .depth (1 << `RAM_AW)
  ) word_ram_inst (
    .clk  (clk),
    .port (ram_bus)
  );

  // result realign and done strobe
  load_aligner load_aligner_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .ld     (ld_bus),
    .done   (done),
    .rdata  (rdata)
  );

endmodule

`default_nettype wire

//--- mem_access_checker.sv
// concurrent assertions on the unit's strobes that the testbench binds into mem_access_top
`default_nettype none

`include "mem_access_macros.svh"

module mem_access_checker (
  input wire logic                   clk,
  input wire logic                   arst_n,
  input wire logic                   req,
  input wire logic                   busy,
  input wire logic                   done,
  input wire logic                   ram_en,
  input wire logic                   ram_we,
  input wire logic [`DATA_W/8-1:0]   ram_wmask
);

  logic accepted;

  assign accepted = req & ~busy;

  done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // done is sampled one edge after it rises so 3 or 4 cycles show up as 4 or 5
  done_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> ($past(accepted, 4) || $past(accepted, 5)))
    else $error("done without an accepted request 3 or 4 cycles earlier");

  busy_falls_with_done: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> done)
    else $error("busy fell without done");

  done_not_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
    else $error("busy still high while done is high");

  write_mask_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    (ram_en && ram_we) |-> (ram_wmask != '0))
    else $error("RAM write with an all-zero byte mask");

endmodule

`default_nettype wire

//--- mem_access_tb.sv
// testbench top for the memory access unit that checks random loads and stores against a byte model
`default_nettype none

`include "mem_access_macros.svh"

module mem_access_tb;

  localparam int period       = 4;
  localparam int reset_cycles = 8;
  localparam int byte_aw      = `RAM_AW + 3;
  localparam int mem_bytes    = 1 << byte_aw;
  localparam int n_pairs      = 24;
  localparam int n_nbr        = 8;
  localparam int n_rand       = 120;
  // aligned and split rounds take up to three accesses each
  localparam int total_ops    = 2 * n_pairs * 3 + n_nbr * 5 + 3 + n_rand;

  logic               clk;
  logic               arst_n;
  logic               req;
  logic               is_store;
  logic [`DATA_W-1:0] addr;
  logic [2:0]         funct3;
  logic [`DATA_W-1:0] wdata;
  logic               done;
  logic [`DATA_W-1:0] rdata;
  logic               busy;

  logic [7:0]         model_mem [mem_bytes];
  logic [31:0]        lfsr_state;
  logic [`DATA_W-1:0] last_rdata;

  mem_access_top mem_access_top_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .is_store (is_store),
    .addr     (addr),
    .funct3   (funct3),
    .wdata    (wdata),
    .done     (done),
    .rdata    (rdata),
    .busy     (busy)
  );

  bind mem_access_top mem_access_checker mem_access_checker_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .busy      (busy),
    .done      (done),
    .ram_en    (ram_bus.en),
    .ram_we    (ram_bus.we),
    .ram_wmask (ram_bus.wmask)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] predict_load(input logic [63:0] rel, input logic [2:0] f3);
    logic [63:0]        value;
    logic [byte_aw-1:0] idx;
    int                 nb;
    value = '0;
    nb = 1 << f3[1:0];
    for (int i = 0; i < nb; i++) begin
      idx = rel[byte_aw-1:0] + i[byte_aw-1:0];
      value[8*i +: 8] = model_mem[idx];
    end
    // lb, lh and lw copy the top loaded bit upward
    if (!f3[2] && nb < 8 && value[8*nb-1]) begin
      value = value | (~64'd0 << (8 * nb));
    end
    return value;
  endfunction

  function automatic void model_store(input logic [63:0] rel, input logic [2:0] f3,
                                      input logic [63:0] data);
    logic [byte_aw-1:0] idx;
    int                 nb;
    nb = 1 << f3[1:0];
    for (int i = 0; i < nb; i++) begin
      idx = rel[byte_aw-1:0] + i[byte_aw-1:0];
      model_mem[idx] = data[8*i +: 8];
    end
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("ERROR time=%0t %s", $time, what);
    abort_run();
  endtask

  // one access with an optional second request thrown in while busy
  task automatic access(input logic st, input logic [63:0] rel, input logic [2:0] f3,
                        input logic [63:0] data, input logic inject);
    int          nb;
    int          cycles;
    int          expect_cycles;
    logic [63:0] expect_rdata;
    nb = 1 << f3[1:0];
    expect_cycles = (int'(rel[2:0]) + nb > 8) ? 4 : 3;
    expect_rdata = st ? last_rdata : predict_load(rel, f3);
    @(posedge clk);
    req      <= 1'b1;
    is_store <= st;
    addr     <= `MEM_BASE + rel;
    funct3   <= f3;
    wdata    <= data;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    assert (busy) else report_failure("busy did not rise after an accepted request");
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (inject && cycles == 1) begin
        req   <= 1'b1;
        addr  <= `MEM_BASE + (rel ^ 64'h40);
        wdata <= ~data;
      end else if (inject && cycles == 2) begin
        req <= 1'b0;
      end
      @(negedge clk);
      if (!done) begin
        assert (busy) else report_failure("busy dropped before done");
      end
    end while (!done);
    assert (cycles == expect_cycles)
      else report_mismatch("done_latency", 64'(expect_cycles), 64'(cycles));
    assert (rdata == expect_rdata) else report_mismatch("rdata", expect_rdata, rdata);
    if (st) begin
      model_store(rel, f3, data);
    end else begin
      last_rdata = expect_rdata;
    end
  endtask

  task automatic store_and_load(input logic [63:0] rel, input logic [1:0] size,
                                input logic top_set);
    logic [63:0] data;
    data = random_bits(64);
    if (top_set) begin
      data[8 * (1 << size) - 1] = 1'b1;
    end
    access(1'b1, rel, {1'b0, size}, data, 1'b0);
    access(1'b0, rel, {1'b0, size}, '0, 1'b0);
    if (size != 2'd3) begin
      access(1'b0, rel, {1'b1, size}, '0, 1'b0);
    end
  endtask

  initial begin
    #((total_ops * 6 + reset_cycles + 16) * period);
    $display("ERROR time=%0t done never arrived within the expected run time", $time);
    abort_run();
  end

  initial begin
    logic [63:0] rel;
    logic [63:0] data;
    logic [1:0]  size;
    logic [2:0]  op_f3;
    int          nb;
    req        = 1'b0;
    is_store   = 1'b0;
    addr       = '0;
    funct3     = 3'd0;
    wdata      = '0;
    arst_n     = 1'b0;
    lfsr_state = 32'd95660;
    last_rdata = '0;
    for (int i = 0; i < mem_bytes; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (!done && !busy) else report_failure("done or busy high after reset");
    assert (rdata == '0) else report_mismatch("rdata", '0, rdata);

    // word aligned accesses of every size with the sign bit set in half of them
    for (int k = 0; k < n_pairs; k++) begin
      rel = random_bits(`RAM_AW) << 3;
      store_and_load(rel, k[1:0], k[2]);
    end

    // accesses crossing a word boundary where the first wraps from the last word
    for (int k = 0; k < n_pairs; k++) begin
      size = 2'd1 + 2'(k % 3);
      nb = 1 << size;
      rel = (k == 0) ? 64'(mem_bytes - 8) : random_bits(`RAM_AW) << 3;
      rel = rel + 64'(9 - nb) + random_bits(3) % 64'(nb - 1);
      store_and_load(rel, size, k[0]);
    end

    // narrow store into two filled words that are both read back whole
    for (int k = 0; k < n_nbr; k++) begin
      rel = random_bits(`RAM_AW) << 3;
      data = random_bits(64);
      access(1'b1, rel, mem_access_pkg::ld, data, 1'b0);
      data = random_bits(64);
      access(1'b1, rel + 64'd8, mem_access_pkg::ld, data, 1'b0);
      size = 2'(random_bits(2) % 3);
      data = random_bits(64);
      access(1'b1, rel + random_bits(3), {1'b0, size}, data, 1'b0);
      access(1'b0, rel, mem_access_pkg::ld, '0, 1'b0);
      access(1'b0, rel + 64'd8, mem_access_pkg::ld, '0, 1'b0);
    end

    // second request while busy has no effect
    rel = random_bits(`RAM_AW) << 3;
    data = random_bits(64);
    access(1'b1, rel, mem_access_pkg::ld, data, 1'b1);
    repeat (3) begin
      @(negedge clk);
      assert (!done) else report_failure("extra done pulse after a dropped request");
    end
    access(1'b0, rel ^ 64'h40, mem_access_pkg::ld, '0, 1'b0);
    access(1'b0, rel, mem_access_pkg::ld, '0, 1'b0);

    // mixed traffic where addresses beyond the RAM wrap by word index
    for (int k = 0; k < n_rand; k++) begin
      rel = random_bits(16);
      data = random_bits(64);
      if (random_bits(1) == 64'd1) begin
        access(1'b1, rel, 3'(random_bits(2)), data, 1'b0);
      end else begin
        op_f3 = 3'(random_bits(3));
        if (op_f3 == 3'd7) begin
          op_f3 = mem_access_pkg::ld;
        end
        access(1'b0, rel, op_f3, '0, 1'b0);
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
mem_access_pkg.sv
mem_access_ifs.sv
mem_req_decoder.sv
mem_access_seq.sv
word_ram.sv
load_aligner.sv
mem_access_top.sv
mem_access_checker.sv
mem_access_tb.sv

//--- Makefile
TOP := mem_access_tb
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
